//--- hw/fastpath_pkg.sv
package fastpath_pkg;

  // address split is {row, bank, col}, burst aligned
  localparam int ROW_BITS = 13;
  localparam int BANK_BITS = 3;
  localparam int NUM_BANKS = 8;
  localparam int COL_BITS = 7;
  localparam int ADDR_BITS = 23;
  localparam int DATA_WIDTH = 32;
  localparam int ID_BITS = 4;

  // one BL8 burst on the x16 device is 4 beats of 32 bits
  localparam int BURST_BEATS = 4;
  localparam int BEAT_BITS = 2;
  localparam int REQ_CREDITS = 4;
  localparam int BEAT_DEPTH = 16;
  localparam int CREDIT_BITS = 8;

  // DDR timing, in controller cycles
  localparam int T_RP = 3;
  localparam int T_RCD = 3;
  localparam int CAS_LAT = 5;
  localparam int TMR_BITS = 2;

  // A10 selects all banks on PRECHARGE
  localparam int AP_BIT = 10;

  // {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    CMD_NOOP = 3'b111,
    CMD_ACTV = 3'b011,
    CMD_PREC = 3'b010,
    CMD_READ = 3'b101,
    CMD_REFR = 3'b001
  } ddr_cmd_e;

  typedef struct packed {
    logic [ID_BITS-1:0] id;
    logic [ADDR_BITS-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    ddr_cmd_e cmd;
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0] addr;
  } ddr_cmd_t;

  typedef struct packed {
    logic [ID_BITS-1:0] id;
    logic [DATA_WIDTH-1:0] data;
    logic last;
  } rd_beat_t;

  typedef struct packed {
    ddr_cmd_e cmd;
    logic [ROW_BITS-1:0] addr;
    logic [ID_BITS-1:0] id;
  } bank_cmd_t;

  function automatic logic [ROW_BITS-1:0] addr_row(logic [ADDR_BITS-1:0] addr);
    return addr[ADDR_BITS-1 -: ROW_BITS];
  endfunction

  function automatic logic [BANK_BITS-1:0] addr_bank(logic [ADDR_BITS-1:0] addr);
    return addr[COL_BITS +: BANK_BITS];
  endfunction

  function automatic logic [COL_BITS-1:0] addr_col(logic [ADDR_BITS-1:0] addr);
    return addr[COL_BITS-1:0];
  endfunction

endpackage

//--- hw/sync_fifo.sv
`timescale 1ns/1ps
module sync_fifo #(
  parameter type T = logic [7:0],
  parameter int DEPTH = 4
) (
  input  logic clock,
  input  logic reset,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o,
  output logic full_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  T mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // storage, no reset needed
  always_ff @(posedge clock) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      // pointers wrap explicitly, depth need not be a power of two
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // first-word fall-through, head is always visible
  assign data_o = mem[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o = (count_q == CNT_W'(DEPTH));
  assign count_o = count_q;

  // the producer must respect the credit or room it was given
  a_no_overflow: assert property (@(posedge clock) disable iff (reset) push_i |-> !full_o)
    else $error("sync_fifo: push while full");
  a_no_underflow: assert property (@(posedge clock) disable iff (reset) pop_i |-> !empty_o)
    else $error("sync_fifo: pop while empty");

endmodule

//--- hw/request_dispatch.sv
`timescale 1ns/1ps
module request_dispatch
  import fastpath_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic req_valid_i,
  input  rd_req_t req_i,
  input  logic [NUM_BANKS-1:0] bank_idle_i,
  output logic req_credit_o,
  output logic [NUM_BANKS-1:0] assign_valid_o,
  output rd_req_t assign_req_o
);

  rd_req_t head;
  logic empty;
  logic [BANK_BITS-1:0] head_bank;
  logic pop;

  // depth equals the requester's credits, so it never overflows
  sync_fifo #(
    .T(rd_req_t),
    .DEPTH(REQ_CREDITS)
  ) u_req_fifo (
    .clock(clock),
    .reset(reset),
    .push_i(req_valid_i),
    .data_i(req_i),
    .pop_i(pop),
    .data_o(head),
    .empty_o(empty),
    .full_o(),
    .count_o()
  );

  assign head_bank = addr_bank(head.addr);

  // hand off only to an idle tracker, so a bank keeps arrival order
  assign pop = !empty && bank_idle_i[head_bank];

  // one credit back per request leaving the queue
  assign req_credit_o = pop;

  // offer the head to its bank only
  always_comb begin
    assign_valid_o = '0;
    if (!empty) begin
      assign_valid_o[head_bank] = 1'b1;
    end
  end

  assign assign_req_o = head;

endmodule

//--- hw/bank_tracker.sv
`timescale 1ns/1ps
module bank_tracker
  import fastpath_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic assign_valid_i,
  input  rd_req_t assign_req_i,
  input  logic grant_i,
  input  logic rows_closed_i,
  output logic bank_idle_o,
  output logic cmd_valid_o,
  output bank_cmd_t cmd_o
);

  logic busy_q;
  rd_req_t req_q;
  logic open_q;
  logic [ROW_BITS-1:0] open_row_q;
  logic [TMR_BITS-1:0] tmr_q;
  logic take;
  logic row_hit;

  assign take = assign_valid_i && !busy_q;
  assign row_hit = open_q && (open_row_q == addr_row(req_q.addr));

  assign bank_idle_o = !busy_q;
  // offer only once tRP or tRCD has run out
  assign cmd_valid_o = busy_q && (tmr_q == '0);

  // next step follows from the open-row state and stays put until granted
  always_comb begin
    cmd_o.id = req_q.id;
    if (row_hit) begin
      // column sits in A9..A3 with A10 low for no auto-precharge
      cmd_o.cmd = CMD_READ;
      cmd_o.addr = {{(ROW_BITS - COL_BITS - 3){1'b0}}, addr_col(req_q.addr), 3'b000};
    end else if (open_q) begin
      // wrong row open so close it first
      cmd_o.cmd = CMD_PREC;
      cmd_o.addr = '0;
    end else begin
      cmd_o.cmd = CMD_ACTV;
      cmd_o.addr = addr_row(req_q.addr);
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q <= 1'b0;
      open_q <= 1'b0;
      tmr_q <= '0;
    end else begin
      if (tmr_q != '0) begin
        tmr_q <= tmr_q - 1'b1;
      end
      if (take) begin
        busy_q <= 1'b1;
      end
      // precharge-all from the refresh sequence
      if (rows_closed_i) begin
        open_q <= 1'b0;
      end
      if (grant_i) begin
        case (cmd_o.cmd)
          CMD_PREC: begin
            open_q <= 1'b0;
            tmr_q <= TMR_BITS'(T_RP - 1);
          end
          CMD_ACTV: begin
            open_q <= 1'b1;
            tmr_q <= TMR_BITS'(T_RCD - 1);
          end
          CMD_READ: busy_q <= 1'b0;
          default: busy_q <= busy_q;
        endcase
      end
    end
  end

  // request and open row registers
  always_ff @(posedge clock) begin
    if (take) begin
      req_q <= assign_req_i;
    end
    if (grant_i && cmd_o.cmd == CMD_ACTV) begin
      open_row_q <= addr_row(req_q.addr);
    end
  end

  // the arbiter only grants what is offered
  a_grant_offered: assert property (@(posedge clock) disable iff (reset)
    grant_i |-> cmd_valid_o)
    else $error("bank_tracker: grant without an offered command");
  // the refresh precharge is on the bus while rows_closed_i is high
  // so a READ granted then would hit a closed row
  a_read_row_open: assert property (@(posedge clock) disable iff (reset)
    grant_i && cmd_o.cmd == CMD_READ |-> !rows_closed_i)
    else $error("bank_tracker: READ granted while the rows are closing");

endmodule

//--- hw/command_arbiter.sv
`timescale 1ns/1ps
module command_arbiter
  import fastpath_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic [NUM_BANKS-1:0] cmd_valid_i,
  input  bank_cmd_t cmd_i [NUM_BANKS],
  input  logic [NUM_BANKS-1:0] bank_idle_i,
  input  logic burst_room_i,
  input  logic refresh_req_i,
  output logic [NUM_BANKS-1:0] grant_o,
  output ddr_cmd_t ddr_cmd_o,
  output logic tag_push_o,
  output logic [ID_BITS-1:0] tag_id_o,
  output logic rows_closed_o,
  output logic refresh_ack_o
);

  typedef enum logic [1:0] {R_IDLE, R_DRAIN, R_WAIT, R_DONE} ref_state_e;

  ref_state_e ref_q;
  logic [TMR_BITS-1:0] ref_tmr_q;
  logic gap_q;
  logic [BANK_BITS-1:0] rr_q;
  logic [BANK_BITS-1:0] pick;
  logic found;
  logic [NUM_BANKS-1:0] eligible;
  logic allow_rd_act;
  logic allow_pre;
  logic quiet;
  logic issue_prea;
  logic issue_refr;
  logic tracker_go;

  // busy trackers parked on an offered command count as quiet, no timer runs
  assign quiet = &(bank_idle_i | cmd_valid_i);
  // no new rows or reads while a refresh is pending
  assign allow_rd_act = (ref_q == R_IDLE && !refresh_req_i) || (ref_q == R_DONE);
  assign allow_pre = (ref_q != R_WAIT);
  assign issue_prea = (ref_q == R_DRAIN) && quiet && !gap_q;
  assign issue_refr = (ref_q == R_WAIT) && (ref_tmr_q == '0) && !gap_q;

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      case (cmd_i[b].cmd)
        // a READ needs room for its whole burst in read_return
        CMD_READ: eligible[b] = allow_rd_act && burst_room_i;
        CMD_ACTV: eligible[b] = allow_rd_act;
        CMD_PREC: eligible[b] = allow_pre;
        default: eligible[b] = 1'b0;
      endcase
      eligible[b] = eligible[b] && cmd_valid_i[b];
    end
  end

  // round robin, lowest offset from rr_q wins
  always_comb begin
    logic [BANK_BITS-1:0] idx;
    found = 1'b0;
    pick = rr_q;
    for (int i = NUM_BANKS - 1; i >= 0; i--) begin
      idx = rr_q + BANK_BITS'(i);
      if (eligible[idx]) begin
        found = 1'b1;
        pick = idx;
      end
    end
  end

  // 2T rate, refresh commands take priority
  assign tracker_go = found && !gap_q && !issue_prea && !issue_refr;

  always_comb begin
    grant_o = '0;
    if (tracker_go) begin
      grant_o[pick] = 1'b1;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ddr_cmd_o <= '{cmd: CMD_NOOP, bank: '0, addr: '0};
      gap_q <= 1'b0;
      rr_q <= '0;
      ref_q <= R_IDLE;
      ref_tmr_q <= '0;
      tag_push_o <= 1'b0;
      rows_closed_o <= 1'b0;
      refresh_ack_o <= 1'b0;
    end else begin
      ddr_cmd_o.cmd <= CMD_NOOP;
      tag_push_o <= 1'b0;
      rows_closed_o <= 1'b0;
      refresh_ack_o <= 1'b0;
      // blocks the cycle after any issue
      gap_q <= tracker_go || issue_prea || issue_refr;
      if (ref_tmr_q != '0) begin
        ref_tmr_q <= ref_tmr_q - 1'b1;
      end
      if (tracker_go) begin
        ddr_cmd_o <= '{cmd: cmd_i[pick].cmd, bank: pick, addr: cmd_i[pick].addr};
        rr_q <= pick + 1'b1;
        tag_push_o <= (cmd_i[pick].cmd == CMD_READ);
      end
      case (ref_q)
        R_IDLE: begin
          if (refresh_req_i) begin
            ref_q <= R_DRAIN;
          end
        end
        R_DRAIN: begin
          if (issue_prea) begin
            ddr_cmd_o <= '{cmd: CMD_PREC, bank: '0, addr: ROW_BITS'(1) << AP_BIT};
            rows_closed_o <= 1'b1;
            ref_tmr_q <= TMR_BITS'(T_RP - 1);
            ref_q <= R_WAIT;
          end
        end
        R_WAIT: begin
          if (issue_refr) begin
            ddr_cmd_o <= '{cmd: CMD_REFR, bank: '0, addr: '0};
            refresh_ack_o <= 1'b1;
            ref_q <= R_DONE;
          end
        end
        default: begin
          // wait for the requester to drop its request
          if (!refresh_req_i) begin
            ref_q <= R_IDLE;
          end
        end
      endcase
    end
  end

  // tag travels with the READ onto the bus
  always_ff @(posedge clock) begin
    if (tracker_go) begin
      tag_id_o <= cmd_i[pick].id;
    end
  end

  a_two_t_rate: assert property (@(posedge clock) disable iff (reset)
    ddr_cmd_o.cmd != CMD_NOOP |=> ddr_cmd_o.cmd == CMD_NOOP)
    else $error("command_arbiter: commands in adjacent cycles");

endmodule

//--- hw/read_return.sv
`timescale 1ns/1ps
module read_return
  import fastpath_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic tag_push_i,
  input  logic [ID_BITS-1:0] tag_id_i,
  input  logic ddl_beat_valid_i,
  input  logic [DATA_WIDTH-1:0] ddl_rdata_i,
  input  logic rsp_credit_i,
  output logic burst_room_o,
  output logic rsp_valid_o,
  output rd_beat_t rsp_beat_o
);

  localparam int TAG_DEPTH = BEAT_DEPTH / BURST_BEATS;

  logic [ID_BITS-1:0] head_id;
  logic id_empty;
  logic [$clog2(TAG_DEPTH+1)-1:0] id_cnt;
  logic [$clog2(BEAT_DEPTH+1)-1:0] beat_cnt;
  logic beat_empty;
  rd_beat_t beat_in;
  logic [BEAT_BITS-1:0] beat_idx_q;
  logic last_beat;
  logic [CREDIT_BITS-1:0] credit_q;
  logic send;
  logic [7:0] slots_needed;

  // IDs of issued READs, in bus order
  sync_fifo #(
    .T(logic [ID_BITS-1:0]),
    .DEPTH(TAG_DEPTH)
  ) u_tag_fifo (
    .clock(clock),
    .reset(reset),
    .push_i(tag_push_i),
    .data_i(tag_id_i),
    .pop_i(ddl_beat_valid_i && last_beat),
    .data_o(head_id),
    .empty_o(id_empty),
    .full_o(),
    .count_o(id_cnt)
  );

  assign last_beat = (beat_idx_q == BEAT_BITS'(BURST_BEATS - 1));
  assign beat_in = '{id: head_id, data: ddl_rdata_i, last: last_beat};

  // beats cannot stall, space was reserved before the READ went out
  sync_fifo #(
    .T(rd_beat_t),
    .DEPTH(BEAT_DEPTH)
  ) u_beat_fifo (
    .clock(clock),
    .reset(reset),
    .push_i(ddl_beat_valid_i),
    .data_i(beat_in),
    .pop_i(send),
    .data_o(rsp_beat_o),
    .empty_o(beat_empty),
    .full_o(),
    .count_o(beat_cnt)
  );

  // a whole burst is reserved for every read still in flight
  assign slots_needed = 8'(beat_cnt) + 8'(id_cnt) * 8'(BURST_BEATS) + 8'(BURST_BEATS);
  assign burst_room_o = (slots_needed <= 8'(BEAT_DEPTH));

  // one beat per consumer credit
  assign send = !beat_empty && (credit_q != '0);
  assign rsp_valid_o = send;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      beat_idx_q <= '0;
      credit_q <= '0;
    end else begin
      if (ddl_beat_valid_i) begin
        beat_idx_q <= last_beat ? '0 : beat_idx_q + 1'b1;
      end
      case ({rsp_credit_i, send})
        2'b10: credit_q <= credit_q + 1'b1;
        2'b01: credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // data only comes back for READs the arbiter issued
  a_beat_has_tag: assert property (@(posedge clock) disable iff (reset)
    ddl_beat_valid_i |-> !id_empty)
    else $error("read_return: data beat with no READ outstanding");

endmodule

//--- hw/fastpath_top.sv
`timescale 1ns/1ps
module fastpath_top
  import fastpath_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic req_valid_i,
  input  rd_req_t req_i,
  output logic req_credit_o,
  output ddr_cmd_t ddr_cmd_o,
  input  logic ddl_beat_valid_i,
  input  logic [DATA_WIDTH-1:0] ddl_rdata_i,
  input  logic rsp_credit_i,
  output logic rsp_valid_o,
  output rd_beat_t rsp_beat_o,
  input  logic refresh_req_i,
  output logic refresh_ack_o
);

  logic [NUM_BANKS-1:0] bank_idle;
  logic [NUM_BANKS-1:0] assign_valid;
  rd_req_t assign_req;
  logic [NUM_BANKS-1:0] grant;
  logic [NUM_BANKS-1:0] cmd_valid;
  bank_cmd_t bank_cmd [NUM_BANKS];
  logic burst_room;
  logic tag_push;
  logic [ID_BITS-1:0] tag_id;
  logic rows_closed;

  request_dispatch u_dispatch (
    .clock(clock),
    .reset(reset),
    .req_valid_i(req_valid_i),
    .req_i(req_i),
    .bank_idle_i(bank_idle),
    .req_credit_o(req_credit_o),
    .assign_valid_o(assign_valid),
    .assign_req_o(assign_req)
  );

  // one tracker per bank, all see the same head request
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    bank_tracker u_tracker (
      .clock(clock),
      .reset(reset),
      .assign_valid_i(assign_valid[b]),
      .assign_req_i(assign_req),
      .grant_i(grant[b]),
      .rows_closed_i(rows_closed),
      .bank_idle_o(bank_idle[b]),
      .cmd_valid_o(cmd_valid[b]),
      .cmd_o(bank_cmd[b])
    );
  end

  command_arbiter u_arbiter (
    .clock(clock),
    .reset(reset),
    .cmd_valid_i(cmd_valid),
    .cmd_i(bank_cmd),
    .bank_idle_i(bank_idle),
    .burst_room_i(burst_room),
    .refresh_req_i(refresh_req_i),
    .grant_o(grant),
    .ddr_cmd_o(ddr_cmd_o),
    .tag_push_o(tag_push),
    .tag_id_o(tag_id),
    .rows_closed_o(rows_closed),
    .refresh_ack_o(refresh_ack_o)
  );

  read_return u_return (
    .clock(clock),
    .reset(reset),
    .tag_push_i(tag_push),
    .tag_id_i(tag_id),
    .ddl_beat_valid_i(ddl_beat_valid_i),
    .ddl_rdata_i(ddl_rdata_i),
    .rsp_credit_i(rsp_credit_i),
    .burst_room_o(burst_room),
    .rsp_valid_o(rsp_valid_o),
    .rsp_beat_o(rsp_beat_o)
  );

endmodule

//--- bench/ddr_pattern.svh
// data of one read beat, a fixed mix of row, bank, column and beat index
// shared by the device model and the checker so both agree on every beat
function automatic logic [DATA_WIDTH-1:0] beat_pattern(
  input logic [ROW_BITS-1:0] row,
  input logic [BANK_BITS-1:0] bank,
  input logic [COL_BITS-1:0] col,
  input int beat
);
  logic [DATA_WIDTH-1:0] raw;
  // 13 + 3 + 7 + 2 + 7 bits, one distinct word per beat
  raw = {row, bank, col, beat[1:0], 7'h2d};
  return raw ^ 32'h5a3c_9e17;
endfunction

//--- bench/ddr_device_model.sv
`timescale 1ns/1ps
module ddr_device_model
  import fastpath_pkg::*;
(
  input  logic clock,
  input  ddr_cmd_t cmd_i,
  output logic beat_valid_o,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic error_o
);

  `include "ddr_pattern.svh"

  logic open_q [NUM_BANKS];
  logic [ROW_BITS-1:0] row_q [NUM_BANKS];
  int last_pre [NUM_BANKS];
  int last_act [NUM_BANKS];
  // scheduled beats, cycle number and data
  int due_q [$];
  logic [DATA_WIDTH-1:0] data_q [$];
  int cyc;
  int bus_free;

  initial begin
    beat_valid_o = 1'b0;
    rdata_o = '0;
    error_o = 1'b0;
    cyc = 0;
    bus_free = 0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      open_q[b] = 1'b0;
      last_pre[b] = -100;
      last_act[b] = -100;
    end
  end

  task automatic report_violation(input string what);
    $display("ddr model: %s at %0t", what, $time);
    error_o <= 1'b1;
  endtask

  // the command seen here was on the bus during the cycle that just ended
  always @(posedge clock) begin
    int start;
    logic [BANK_BITS-1:0] b;
    cyc++;
    b = cmd_i.bank;
    case (cmd_i.cmd)
      CMD_ACTV: begin
        if (open_q[b]) report_violation("ACTIVATE to a bank with an open row");
        if (cyc - last_pre[b] < T_RP) report_violation("tRP too short before ACTIVATE");
        open_q[b] = 1'b1;
        row_q[b] = cmd_i.addr;
        last_act[b] = cyc;
      end
      CMD_PREC: begin
        // A10 high closes every bank
        for (int i = 0; i < NUM_BANKS; i++) begin
          if (cmd_i.addr[AP_BIT] || i == int'(b)) begin
            open_q[i] = 1'b0;
            last_pre[i] = cyc;
          end
        end
      end
      CMD_READ: begin
        if (!open_q[b]) report_violation("READ to a bank with no open row");
        if (cyc - last_act[b] < T_RCD) report_violation("tRCD too short before READ");
        // bursts queue behind each other on the data bus
        start = cyc - 1 + CAS_LAT;
        if (bus_free > start) start = bus_free;
        for (int j = 0; j < BURST_BEATS; j++) begin
          due_q.push_back(start + j);
          data_q.push_back(beat_pattern(row_q[b], b, cmd_i.addr[COL_BITS+2:3], j));
        end
        bus_free = start + BURST_BEATS;
      end
      CMD_REFR: begin
        for (int i = 0; i < NUM_BANKS; i++) begin
          if (open_q[i]) report_violation("REFRESH while a row is open");
          if (cyc - last_pre[i] < T_RP) report_violation("tRP too short before REFRESH");
        end
      end
      default: ;
    endcase
    // beats change just after the edge, like every other input
    #1;
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      beat_valid_o = 1'b1;
      rdata_o = data_q.pop_front();
      void'(due_q.pop_front());
    end else begin
      beat_valid_o = 1'b0;
    end
  end

endmodule

//--- bench/tb_fastpath_top.sv
`timescale 1ns/1ps
module tb_fastpath_top
  import fastpath_pkg::*;
();

  `include "ddr_pattern.svh"

  localparam int NUM_REQS = 300;
  localparam int MAX_OUTSTANDING = 8;
  localparam int TIMEOUT_CYCLES = NUM_REQS * 60;
  localparam int NUM_IDS = 1 << ID_BITS;

  logic clock;
  logic reset;
  logic req_valid_i;
  rd_req_t req_i;
  logic req_credit_o;
  ddr_cmd_t ddr_cmd_o;
  logic ddl_beat_valid_i;
  logic [DATA_WIDTH-1:0] ddl_rdata_i;
  logic rsp_credit_i;
  logic rsp_valid_o;
  rd_beat_t rsp_beat_o;
  logic refresh_req_i;
  logic refresh_ack_o;
  logic model_err;

  logic [15:0] lfsr_q;
  int req_credits;
  int outstanding;
  int sent;
  int answered;
  int beats_sent;
  int rsp_credits_given;
  int credit_pulses;
  int refresh_reqs;
  int refresh_acks;
  int cycles;
  // reference model with one entry per ID
  logic [ADDR_BITS-1:0] exp_addr [NUM_IDS];
  logic pending [NUM_IDS];
  int beat_idx [NUM_IDS];
  int seq_of [NUM_IDS];
  // newest sequence number finished per bank
  int last_seq [NUM_BANKS];

  fastpath_top u_dut (
    .clock(clock),
    .reset(reset),
    .req_valid_i(req_valid_i),
    .req_i(req_i),
    .req_credit_o(req_credit_o),
    .ddr_cmd_o(ddr_cmd_o),
    .ddl_beat_valid_i(ddl_beat_valid_i),
    .ddl_rdata_i(ddl_rdata_i),
    .rsp_credit_i(rsp_credit_i),
    .rsp_valid_o(rsp_valid_o),
    .rsp_beat_o(rsp_beat_o),
    .refresh_req_i(refresh_req_i),
    .refresh_ack_o(refresh_ack_o)
  );

  ddr_device_model u_ddr (
    .clock(clock),
    .cmd_i(ddr_cmd_o),
    .beat_valid_o(ddl_beat_valid_i),
    .rdata_o(ddl_rdata_i),
    .error_o(model_err)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_count(input string name, input integer got, input integer exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      fail_run("count mismatch");
    end
  endtask

  task automatic check_cmd(input string name, input ddr_cmd_t got, input ddr_cmd_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      fail_run("command mismatch");
    end
  endtask

  task automatic check_beat(input string name, input rd_beat_t got, input rd_beat_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is id %0h data %08h last %0b, %s", $time, name,
        got.id, got.data, got.last,
        $sformatf("expected id %0h data %08h last %0b", exp.id, exp.data, exp.last));
      fail_run("beat mismatch");
    end
  endtask

  // galois LFSR stepped once per bit taken
  function automatic int unsigned draw(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr_q[0];
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // rows come from a pool of four so that hits, misses and closed banks all happen
  task automatic send_request();
    int unsigned row;
    int unsigned bank;
    int unsigned col;
    int id;
    logic [ADDR_BITS-1:0] addr;
    row = draw(2);
    bank = draw(BANK_BITS);
    col = draw(COL_BITS);
    id = sent % NUM_IDS;
    addr = {ROW_BITS'(row), BANK_BITS'(bank), COL_BITS'(col)};
    req_i = '{id: ID_BITS'(id), addr: addr};
    req_valid_i = 1'b1;
    exp_addr[id] = addr;
    pending[id] = 1'b1;
    beat_idx[id] = 0;
    seq_of[id] = sent;
    req_credits--;
    outstanding++;
    sent++;
  endtask

  task automatic take_beat();
    int id;
    int b;
    rd_beat_t exp;
    logic [ADDR_BITS-1:0] a;
    id = rsp_beat_o.id;
    if (!pending[id]) fail_run($sformatf("beat at %0t for ID %0d with no open request", $time, id));
    beats_sent++;
    if (beats_sent > rsp_credits_given) fail_run("more response beats than credits granted");
    // address fields are {row, bank, col}
    a = exp_addr[id];
    b = a[COL_BITS +: BANK_BITS];
    exp.id = ID_BITS'(id);
    exp.data = beat_pattern(a[ADDR_BITS-1 -: ROW_BITS], b, a[COL_BITS-1:0], beat_idx[id]);
    exp.last = (beat_idx[id] == BURST_BEATS - 1);
    check_beat("rsp_beat_o", rsp_beat_o, exp);
    beat_idx[id]++;
    if (exp.last) begin
      // same bank must finish in request order
      if (seq_of[id] < last_seq[b]) begin
        fail_run($sformatf("bank %0d finished request %0d after request %0d",
          b, seq_of[id], last_seq[b]));
      end
      last_seq[b] = seq_of[id];
      pending[id] = 1'b0;
      outstanding--;
      answered++;
    end
  endtask

  // outputs are sampled on the edge while inputs change 1 ns later
  always @(posedge clock) begin
    if (!reset) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_run($sformatf("timeout after %0d cycles", cycles));
      if (model_err) fail_run("DDR device model saw a protocol error");
      if (req_credit_o) begin
        req_credits++;
        credit_pulses++;
      end
      if (refresh_ack_o) begin
        if (refresh_acks >= refresh_reqs) fail_run("refresh_ack_o with no refresh pending");
        refresh_acks++;
      end
      if (rsp_valid_o) take_beat();
      // a credit seen on this edge only pays for a later beat
      if (rsp_credit_i) rsp_credits_given++;
    end
  end

  initial begin
    int unsigned r;
    int hold;
    reset = 1'b1;
    req_valid_i = 1'b0;
    req_i = '0;
    rsp_credit_i = 1'b0;
    refresh_req_i = 1'b0;
    lfsr_q = 16'd1816;
    req_credits = REQ_CREDITS;
    outstanding = 0;
    sent = 0;
    answered = 0;
    beats_sent = 0;
    rsp_credits_given = 0;
    credit_pulses = 0;
    refresh_reqs = 0;
    refresh_acks = 0;
    cycles = 0;
    hold = 0;
    for (int i = 0; i < NUM_IDS; i++) pending[i] = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) last_seq[b] = -1;
    repeat (16) @(posedge clock);
    #1 reset = 1'b0;
    @(posedge clock);
    // quiet outputs out of reset
    check_count("req_credit_o", req_credit_o, 0);
    check_count("rsp_valid_o", rsp_valid_o, 0);
    check_count("refresh_ack_o", refresh_ack_o, 0);
    check_cmd("ddr_cmd_o", ddr_cmd_o, '{cmd: CMD_NOOP, bank: '0, addr: '0});
    while (answered < NUM_REQS) begin
      @(posedge clock);
      #1;
      // response credits come with random gaps and now and then a long hold-off
      r = draw(6);
      if (hold > 0) begin
        rsp_credit_i = 1'b0;
        hold--;
      end else if (r == 0) begin
        rsp_credit_i = 1'b0;
        hold = 40;
      end else begin
        rsp_credit_i = (r[1:0] != 0);
      end
      // refresh stays up until its ack
      if (refresh_req_i) begin
        if (refresh_acks == refresh_reqs) refresh_req_i = 1'b0;
      end else if (sent < NUM_REQS) begin
        r = draw(7);
        if (r == 0) begin
          refresh_req_i = 1'b1;
          refresh_reqs++;
        end
      end
      req_valid_i = 1'b0;
      r = draw(1);
      if (sent < NUM_REQS && req_credits > 0 && outstanding < MAX_OUTSTANDING &&
          !pending[sent % NUM_IDS] && r[0]) begin
        send_request();
      end
    end
    // spare credits would expose any stray beat
    // and a refresh still pending gets its ack here
    @(posedge clock);
    #1;
    req_valid_i = 1'b0;
    rsp_credit_i = 1'b1;
    repeat (40) @(posedge clock);
    check_count("req_credit_o pulses", credit_pulses, NUM_REQS);
    check_count("refresh_ack_o pulses", refresh_acks, refresh_reqs);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- project.f
+incdir+bench
hw/fastpath_pkg.sv
hw/sync_fifo.sv
hw/request_dispatch.sv
hw/bank_tracker.sv
hw/command_arbiter.sv
hw/read_return.sv
hw/fastpath_top.sv
bench/ddr_device_model.sv
bench/tb_fastpath_top.sv

//--- Bender.yml
package:
  name: ddr3_read_fastpath

sources:
  - files:
      - hw/fastpath_pkg.sv
      - hw/sync_fifo.sv
      - hw/request_dispatch.sv
      - hw/bank_tracker.sv
      - hw/command_arbiter.sv
      - hw/read_return.sv
      - hw/fastpath_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/ddr_device_model.sv
      - bench/tb_fastpath_top.sv
